/* sv32_mmu.f */
+incdir+.
sv32_pkg.sv
axi_rd_pkg.sv
xlat_fifo.sv
sv32_ptw.sv
pt_mem_axi.sv
sv32_mmu.sv
tb_clk_gen.sv
sv32_mmu_sva.sv
tb_sv32_mmu.sv

/* Bender.yml */
package:
  name: sv32_mmu

export_include_dirs:
  - .

sources:
  # packages first, then the RTL
  - include_dirs:
      - .
    files:
      - sv32_pkg.sv
      - axi_rd_pkg.sv
      - xlat_fifo.sv
      - sv32_ptw.sv
      - pt_mem_axi.sv
      - sv32_mmu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - sv32_mmu_sva.sv
      - tb_sv32_mmu.sv

/* tb_sv32_mmu.sv */
`timescale 1ns/10ps
`include "sv32_mmu_cfg.svh"

module tb_sv32_mmu;

    import sv32_pkg::*;

    localparam int ROWS        = 12;
    localparam int PASSES      = 2;
    localparam int N_TESTS     = ROWS * PASSES;
    localparam int RST_CYCLES  = 5;
    localparam int CLEAR_WORDS = 2048;
    localparam int CLK_NS      = 8;
    // table build time plus the per-test budget
    localparam int WATCHDOG_CYCLES = RST_CYCLES + CLEAR_WORDS + 16 + N_TESTS * 40 + 200;

    logic                             clk;
    logic                             rst_n;
    logic                             req_valid;
    logic                             req_ready;
    logic [`SV32_VPN_W-1:0]           req_vpn;
    logic                             res_valid;
    logic                             res_ready;
    logic [XLAT_RES_W-1:0]            res_data;
    logic [`SV32_PPN_W-1:0]           satp_ppn;
    logic                             pt_wr_en;
    logic [`PT_MEM_AW-1:0]            pt_wr_addr;
    logic [axi_rd_pkg::AXI_DATA_W-1:0] pt_wr_data;

    // vector table
    logic [`SV32_VPN_W-1:0] row_vpn   [ROWS];
    logic [1:0]             row_fault [ROWS];
    logic [`SV32_PPN_W-1:0] row_ppn   [ROWS];
    logic [7:0]             row_meta  [ROWS];

    int         res_count  = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    int         err_count  = 0;
    logic       throttle   = 1'b0;
    logic [7:0] lfsr;

    tb_clk_gen #(.HALF_PERIOD_NS(CLK_NS / 2)) u_clk (.clk(clk));

    sv32_mmu dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_vpn    (req_vpn),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_data   (res_data),
        .satp_ppn   (satp_ppn),
        .pt_wr_en   (pt_wr_en),
        .pt_wr_addr (pt_wr_addr),
        .pt_wr_data (pt_wr_data)
    );

    bind sv32_ptw sv32_mmu_sva u_sva (
        .clk         (clk),
        .rst_n       (rst_n),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res_data    (res_data)
    );

    // x^8 + x^6 + x^5 + x^4 + 1, new bit shifts in at bit 0
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic set_row(input int i, input logic [19:0] vpn, input logic [1:0] fault,
                           input logic [21:0] ppn, input logic [7:0] meta);
        row_vpn[i]   = vpn;
        row_fault[i] = fault;
        row_ppn[i]   = ppn;
        row_meta[i]  = meta;
    endtask

    // expected values follow the walk rules against the tables built below
    task automatic load_vectors();
        // megapage at vpn1 1, ppn {123, vpn0}, flags DAXWRV
        set_row(0, 20'h00455, FAULT_NONE, 22'h048C55, 8'hCF);
        // two-level walk through page 1 to a 4 KiB leaf
        set_row(1, 20'h00810, FAULT_NONE, 22'h2ABCD, 8'h5B);
        // megapage with ppn[9:0] of 5
        set_row(2, 20'h00C00, FAULT_PAGE, 22'h0, 8'h00);
        // V clear
        set_row(3, 20'h01000, FAULT_PAGE, 22'h0, 8'h00);
        // W without R
        set_row(4, 20'h01400, FAULT_PAGE, 22'h0, 8'h00);
        // pointer found at level 0
        set_row(5, 20'h00820, FAULT_PAGE, 22'h0, 8'h00);
        // next level table at ppn 100000, outside the memory
        set_row(6, 20'h01801, FAULT_ACCESS, 22'h0, 8'h00);
        // empty slot in page 1
        set_row(7, 20'h00833, FAULT_PAGE, 22'h0, 8'h00);
        set_row(8, 20'h007FF, FAULT_NONE, 22'h048FFF, 8'hCF);
        set_row(9, 20'h00810, FAULT_NONE, 22'h2ABCD, 8'h5B);
        // empty root slot
        set_row(10, 20'h01C00, FAULT_PAGE, 22'h0, 8'h00);
        set_row(11, 20'h01801, FAULT_ACCESS, 22'h0, 8'h00);
    endtask

    // one word per cycle through the load port
    task automatic write_word(input logic [11:0] addr, input logic [31:0] data);
        pt_wr_en   = 1'b1;
        pt_wr_addr = addr;
        pt_wr_data = data;
        @(posedge clk);
        #1;
    endtask

    task automatic build_tables();
        // empty slots keep V clear, the word index sits above the flag byte
        for (int w = 0; w < CLEAR_WORDS; w++) begin
            write_word(12'(w), 32'(w) << 8);
        end
        // root table in page 0, index vpn1
        write_word(12'd1, 32'h123000CF);
        write_word(12'd2, 32'h00000401);
        write_word(12'd3, 32'h00001403);
        write_word(12'd4, 32'h12300006);
        write_word(12'd5, 32'h00001005);
        write_word(12'd6, 32'h40000001);
        // leaf table in page 1, word 1024 + vpn0
        write_word(12'h410, 32'h0AAF345B);
        write_word(12'h420, 32'h00000801);
        pt_wr_en = 1'b0;
    endtask

    // called at posedge + 1, valid stays up until the accepting edge
    task automatic send_req(input logic [19:0] vpn);
        req_valid = 1'b1;
        req_vpn   = vpn;
        while (!req_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_result(input int t, input logic [31:0] word);
        int  r;
        logic bad;
        r   = t % ROWS;
        bad = 1'b0;
        if (word[31:30] != row_fault[r]) begin
            $display("CHECK FAILED at %0t: test %0d fault %0d expected %0d",
                     $time, t, word[31:30], row_fault[r]);
            bad = 1'b1;
        end
        if (word[29:22] != row_meta[r]) begin
            $display("CHECK FAILED at %0t: test %0d meta %02h expected %02h",
                     $time, t, word[29:22], row_meta[r]);
            bad = 1'b1;
        end
        if (word[21:0] != row_ppn[r]) begin
            $display("CHECK FAILED at %0t: test %0d ppn %06h expected %06h",
                     $time, t, word[21:0], row_ppn[r]);
            bad = 1'b1;
        end
        if (bad) begin
            fail_count++;
        end else begin
            pass_count++;
        end
        $display("test %0d vpn %05h: %s", t, row_vpn[r], bad ? "mismatch" : "ok");
    endtask

    // result consumer, decides res_ready and takes words at posedge + 1
    initial begin : consumer
        logic [2:0] ready_bits;
        res_ready = 1'b0;
        lfsr      = 8'd70;
        forever begin
            @(posedge clk);
            #1;
            if (throttle) begin
                // ready only when three fresh bits are all set
                // so the result queue fills and the walker stalls in RESP
                for (int k = 0; k < 3; k++) begin
                    lfsr          = lfsr_step(lfsr);
                    ready_bits[k] = lfsr[0];
                end
                res_ready = &ready_bits;
            end else begin
                res_ready = 1'b1;
            end
            if (res_valid && res_ready) begin
                if (res_count >= N_TESTS) begin
                    $display("error at %0t: result seen with no request left", $time);
                    err_count++;
                end else begin
                    check_result(res_count, res_data);
                end
                res_count++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("error: run timed out with %0d of %0d results", res_count, N_TESTS);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_vpn    = '0;
        satp_ppn   = '0;
        pt_wr_en   = 1'b0;
        pt_wr_addr = '0;
        pt_wr_data = '0;
        load_vectors();
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        build_tables();
        // first pass drains freely, second throttles res_ready
        for (int p = 0; p < PASSES; p++) begin
            throttle = (p == 1);
            for (int i = 0; i < ROWS; i++) begin
                send_req(row_vpn[i]);
            end
            req_valid = 1'b0;
            wait (res_count >= (p + 1) * ROWS);
        end
        // queues must be empty once every result is in
        repeat (20) @(posedge clk);
        #1;
        if (res_valid || res_count != N_TESTS) begin
            $display("error: result queue not empty after the last result");
            err_count++;
        end
        $display("tests passed %0d, failed %0d, other errors %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sv32_mmu_sva.sv */
`timescale 1ns/10ps
`include "sv32_mmu_cfg.svh"

module sv32_mmu_sva (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            axi_arvalid,
    input logic                            axi_arready,
    input logic [`SV32_PADDR_W-1:0]        axi_araddr,
    input logic                            res_valid,
    input logic                            res_ready,
    input logic [sv32_pkg::XLAT_RES_W-1:0] res_data
);

    import sv32_pkg::*;

    // AR request held with a steady address until accepted
    property p_ar_hold;
        @(posedge clk) disable iff (!rst_n)
        axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr);
    endproperty

    // result offer held with steady data until taken
    property p_res_hold;
        @(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(res_data);
    endproperty

    // the walker never reads the bus while offering a result
    property p_ar_res_exclusive;
        @(posedge clk) disable iff (!rst_n)
        !(axi_arvalid && res_valid);
    endproperty

    a_ar_hold: assert property (p_ar_hold)
        else $error("arvalid or araddr changed before arready");
    a_res_hold: assert property (p_res_hold)
        else $error("res_valid or res_data changed before res_ready");
    a_ar_res_exclusive: assert property (p_ar_res_exclusive)
        else $error("arvalid and res_valid high in the same cycle");

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 4
) (
    output logic clk
);

    // free running, 8 ns period with the default
    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

/* sv32_mmu.sv */
`timescale 1ns/10ps
`include "sv32_mmu_cfg.svh"

module sv32_mmu (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  logic [`SV32_VPN_W-1:0]            req_vpn,
    output logic                              res_valid,
    input  logic                              res_ready,
    output logic [sv32_pkg::XLAT_RES_W-1:0]   res_data,
    input  logic [`SV32_PPN_W-1:0]            satp_ppn,
    input  logic                              pt_wr_en,
    input  logic [`PT_MEM_AW-1:0]             pt_wr_addr,
    input  logic [axi_rd_pkg::AXI_DATA_W-1:0] pt_wr_data
);

    import sv32_pkg::*;
    import axi_rd_pkg::*;

    // request queue to walker
    logic                   q_req_valid;
    logic                   q_req_ready;
    logic [`SV32_VPN_W-1:0] q_req_vpn;

    // walker to result queue
    logic                   ptw_res_valid;
    logic                   ptw_res_ready;
    logic [XLAT_RES_W-1:0]  ptw_res_data;

    // read bus between walker and page table memory
    logic                     axi_arvalid;
    logic                     axi_arready;
    logic [`SV32_PADDR_W-1:0] axi_araddr;
    logic                     axi_rvalid;
    logic                     axi_rready;
    axi_resp_e                axi_rresp;
    logic [AXI_DATA_W-1:0]    axi_rdata;

    xlat_fifo #(
        .WIDTH (`SV32_VPN_W)
    ) u_req_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req_vpn),
        .out_valid (q_req_valid),
        .out_ready (q_req_ready),
        .out_data  (q_req_vpn)
    );

    // one walk at a time, results leave in request order
    sv32_ptw u_ptw (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (q_req_valid),
        .req_ready   (q_req_ready),
        .req_vpn     (q_req_vpn),
        .satp_ppn    (satp_ppn),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready),
        .axi_rresp   (axi_rresp),
        .axi_rdata   (axi_rdata),
        .res_valid   (ptw_res_valid),
        .res_ready   (ptw_res_ready),
        .res_data    (ptw_res_data)
    );

    pt_mem_axi u_pt_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (axi_arvalid),
        .arready (axi_arready),
        .araddr  (axi_araddr),
        .rvalid  (axi_rvalid),
        .rready  (axi_rready),
        .rresp   (axi_rresp),
        .rdata   (axi_rdata),
        .wr_en   (pt_wr_en),
        .wr_addr (pt_wr_addr),
        .wr_data (pt_wr_data)
    );

    // absorbs back-pressure from the consumer
    xlat_fifo #(
        .WIDTH (XLAT_RES_W)
    ) u_res_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ptw_res_valid),
        .in_ready  (ptw_res_ready),
        .in_data   (ptw_res_data),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_data  (res_data)
    );

endmodule

/* pt_mem_axi.sv */
`timescale 1ns/10ps
`include "sv32_mmu_cfg.svh"

module pt_mem_axi (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              arvalid,
    output logic                              arready,
    input  logic [`SV32_PADDR_W-1:0]          araddr,
    output logic                              rvalid,
    input  logic                              rready,
    output axi_rd_pkg::axi_resp_e             rresp,
    output logic [axi_rd_pkg::AXI_DATA_W-1:0] rdata,
    input  logic                              wr_en,
    input  logic [`PT_MEM_AW-1:0]             wr_addr,
    input  logic [axi_rd_pkg::AXI_DATA_W-1:0] wr_data
);

    import axi_rd_pkg::*;

    // page table storage, word addressed
    logic [AXI_DATA_W-1:0] mem [`PT_MEM_WORDS];

    logic                  ar_fire;
    logic                  r_fire;
    logic                  out_of_range;
    logic [`PT_MEM_AW-1:0] rd_idx;

    // one read outstanding at most, rvalid doubles as the pending flag
    assign arready = !rvalid;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // anything above the 16 KiB window decodes to nothing
    assign out_of_range = (araddr[`SV32_PADDR_W-1:`PT_MEM_AW+2] != '0);
    // byte offset bits [1:0] are ignored, reads are whole words
    assign rd_idx       = araddr[`PT_MEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            // data is offered on the cycle after the AR transfer
            rvalid <= 1'b1;
        end else if (r_fire) begin
            rvalid <= 1'b0;
        end
    end

    // response captured on AR, held until the R transfer
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            if (out_of_range) begin
                rresp <= SLVERR;
                rdata <= '0;
            end else begin
                rresp <= OKAY;
                rdata <= mem[rd_idx];
            end
        end
    end

    // load port used to build the tables
    // a read of the same word on the same edge sees the old value
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

/* sv32_ptw.sv */
`timescale 1ns/10ps
`include "sv32_mmu_cfg.svh"

module sv32_ptw (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  logic [`SV32_VPN_W-1:0]            req_vpn,
    input  logic [`SV32_PPN_W-1:0]            satp_ppn,
    output logic                              axi_arvalid,
    input  logic                              axi_arready,
    output logic [`SV32_PADDR_W-1:0]          axi_araddr,
    input  logic                              axi_rvalid,
    output logic                              axi_rready,
    input  axi_rd_pkg::axi_resp_e             axi_rresp,
    input  logic [axi_rd_pkg::AXI_DATA_W-1:0] axi_rdata,
    output logic                              res_valid,
    input  logic                              res_ready,
    output logic [sv32_pkg::XLAT_RES_W-1:0]   res_data
);

    import sv32_pkg::*;
    import axi_rd_pkg::*;

    // control state
    walk_state_e state;
    // 1 while reading the root table, 0 for the leaf table
    logic        level;
    // latched rresp != OKAY of the last PTE read
    logic        bus_err;

    // walk payload
    logic [`SV32_PPN_W-1:0] table_base;
    logic [`SV32_VPN_W-1:0] saved_vpn;
    logic [AXI_DATA_W-1:0]  saved_pte;

    // decode of the saved PTE
    logic [9:0]             vpn_slice;
    logic                   pte_invalid;
    logic                   pte_leaf;
    logic                   pte_misaligned;
    logic                   walk_next;
    xlat_fault_e            fault;
    logic [`SV32_PPN_W-1:0] res_ppn;
    logic [7:0]             res_meta;

    // vpn[1] indexes the root table, vpn[0] the leaf table
    assign vpn_slice  = level ? saved_vpn[19:10] : saved_vpn[9:0];
    // each PTE is 4 bytes
    assign axi_araddr = {table_base, vpn_slice, 2'b00};

    // W without R is a reserved encoding
    assign pte_invalid    = !saved_pte[PTE_V] || (saved_pte[PTE_W] && !saved_pte[PTE_R]);
    assign pte_leaf       = saved_pte[PTE_R] || saved_pte[PTE_X];
    // a megapage must be aligned to 4 MiB, so ppn[9:0] must be zero
    assign pte_misaligned = level && (saved_pte[19:10] != 10'd0);

    // classification, priority as listed in the Sv32 walk algorithm
    always_comb begin
        fault     = FAULT_NONE;
        walk_next = 1'b0;
        if (bus_err) begin
            fault = FAULT_ACCESS;
        end else if (pte_invalid) begin
            fault = FAULT_PAGE;
        end else if (pte_leaf) begin
            if (pte_misaligned) begin
                fault = FAULT_PAGE;
            end
        end else if (level) begin
            // valid pointer in the root table, descend
            walk_next = 1'b1;
        end else begin
            // pointer where a leaf is required
            fault = FAULT_PAGE;
        end
    end

    // megapage keeps the low vpn bits as ppn[9:0]
    always_comb begin
        if (fault != FAULT_NONE) begin
            res_ppn  = '0;
            res_meta = '0;
        end else begin
            res_ppn  = level ? {saved_pte[31:20], saved_vpn[9:0]} : saved_pte[31:10];
            res_meta = saved_pte[7:0];
        end
    end

    // decode stays stable through RESP since nothing is captured there
    assign res_data = {fault, res_meta, res_ppn};

    // handshake outputs straight from the state register
    assign req_ready   = (state == ST_IDLE);
    assign axi_arvalid = (state == ST_AR);
    assign axi_rready  = (state == ST_R);
    assign res_valid   = (state == ST_RESP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            level   <= 1'b1;
            bus_err <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        level <= 1'b1;
                        state <= ST_AR;
                    end
                end
                ST_AR: begin
                    if (axi_arready) begin
                        state <= ST_R;
                    end
                end
                ST_R: begin
                    if (axi_rvalid) begin
                        bus_err <= (axi_rresp != OKAY);
                        state   <= ST_WALK;
                    end
                end
                ST_WALK: begin
                    if (walk_next) begin
                        level <= 1'b0;
                        state <= ST_AR;
                    end else begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // hold until the result queue takes it
                    if (res_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // start of a walk, root table from satp
        if (state == ST_IDLE && req_valid) begin
            saved_vpn  <= req_vpn;
            table_base <= satp_ppn;
        end
        if (state == ST_R && axi_rvalid) begin
            saved_pte <= axi_rdata;
        end
        // next level table base is the pointer's ppn
        if (state == ST_WALK && walk_next) begin
            table_base <= saved_pte[31:10];
        end
    end

endmodule

/* xlat_fifo.sv */
`timescale 1ns/10ps
`include "sv32_mmu_cfg.svh"

module xlat_fifo #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    localparam int DEPTH = `XLAT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // circular storage, read side is combinational
    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    // goes high one edge after reset is released
    logic             accept_en;
    logic             full;
    logic             push;
    logic             pop;

    assign full      = (count == CNT_W'(DEPTH));
    // a pop on the same edge frees the slot being written
    assign in_ready  = accept_en && (!full || out_ready);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            accept_en <= 1'b0;
        end else begin
            accept_en <= 1'b1;
            // pointers wrap at DEPTH, not only at a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy moves only when exactly one side fires
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // write port, data visible at out_data from the next cycle
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* axi_rd_pkg.sv */
package axi_rd_pkg;

    // width of the response field on the R channel
    localparam int AXI_RESP_W = 2;

    // read data width, one PTE per beat
    localparam int AXI_DATA_W = 32;

    // standard AXI response codes
    // only OKAY and SLVERR come out of the page table memory
    typedef enum logic [AXI_RESP_W-1:0] {
        OKAY   = 2'd0,
        EXOKAY = 2'd1,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } axi_resp_e;

endpackage

/* sv32_pkg.sv */
package sv32_pkg;

    // bit positions inside a 32-bit Sv32 PTE
    // ppn sits in [31:10], rsw in [9:8], flags below
    typedef enum logic [2:0] {
        PTE_V = 3'd0,
        PTE_R = 3'd1,
        PTE_W = 3'd2,
        PTE_X = 3'd3,
        PTE_U = 3'd4,
        PTE_G = 3'd5,
        PTE_A = 3'd6,
        PTE_D = 3'd7
    } pte_bit_e;

    // walker FSM states
    // ST_AR issues the PTE read, ST_R waits for data,
    // ST_WALK classifies the PTE, ST_RESP offers the result
    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_AR   = 3'd1,
        ST_R    = 3'd2,
        ST_WALK = 3'd3,
        ST_RESP = 3'd4
    } walk_state_e;

    // translation outcome carried in the top bits of a result word
    typedef enum logic [1:0] {
        FAULT_NONE   = 2'd0,
        FAULT_PAGE   = 2'd1,
        FAULT_ACCESS = 2'd2
    } xlat_fault_e;

    // result word layout
    //   [31:30] fault code
    //   [29:22] PTE flag byte, zero on a fault
    //   [21:0]  physical page number, zero on a fault
    localparam int XLAT_RES_W = 32;

endpackage

/* sv32_mmu_cfg.svh */
`ifndef SV32_MMU_CFG_SVH
`define SV32_MMU_CFG_SVH

// Sv32 address widths
// virtual page number, the upper 20 bits of a 32-bit virtual address
`define SV32_VPN_W 20

// physical page number as held in a PTE and in satp
`define SV32_PPN_W 22

// physical byte address, ppn plus 12-bit page offset
`define SV32_PADDR_W 34

// request queue and result queue share this depth
`define XLAT_FIFO_DEPTH 4

// page table memory, 32-bit words
// 4096 words is 16 KiB, enough for four 4 KiB tables
`define PT_MEM_WORDS 4096

// word index width into the page table memory
// byte addresses at or above 1 << (PT_MEM_AW + 2) are out of range
`define PT_MEM_AW 12

`endif
